/* common/acc_cfg_pkg.sv */
package acc_cfg_pkg;

  // Feature map geometry
  localparam int FMAP_DIM = 8;
  localparam int FMAP_PIX = FMAP_DIM * FMAP_DIM;

  // 3x3 kernel with valid padding
  localparam int KERNEL_DIM  = 3;
  localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;
  localparam int CONV3_DIM   = FMAP_DIM - KERNEL_DIM + 1;

  // 2x2 window, stride 2
  localparam int POOL_WIN = 2;
  localparam int POOL_DIM = FMAP_DIM / POOL_WIN;

  // RAM port widths
  localparam int ADDR_W = $clog2(FMAP_PIX);
  localparam int DATA_W = 32;

  // Signed pixel and weight byte
  localparam int PIX_W = 8;

endpackage

/* common/acc_ops_pkg.sv */
package acc_ops_pkg;

  // Operation select, all other codes are rejected
  typedef enum logic [3:0] {
    MODE_CONV_1X1 = 4'h1,
    MODE_CONV_3X3 = 4'h2,
    MODE_MAX_POOL = 4'h3
  } acc_mode_e;

  // Common FSM states of the compute units
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_LOAD  = 2'd1,
    ST_RUN   = 2'd2,
    ST_DRAIN = 2'd3
  } unit_state_e;

  function automatic logic mode_valid(acc_mode_e mode);
    return mode inside {MODE_CONV_1X1, MODE_CONV_3X3, MODE_MAX_POOL};
  endfunction

endpackage

/* src/bus_switcher.sv */
`timescale 1ns/1ps

module bus_switcher import acc_cfg_pkg::*, acc_ops_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  acc_mode_e         mode_i,
  output logic              finish_o,
  output logic              in_req_o,
  output logic [ADDR_W-1:0] in_addr_o,
  output logic              wt_req_o,
  output logic [ADDR_W-1:0] wt_addr_o,
  output logic              out_we_o,
  output logic [ADDR_W-1:0] out_addr_o,
  output logic [DATA_W-1:0] out_wdata_o,
  output logic              c1_start_o,
  input  logic              c1_finish_i,
  input  logic              c1_in_req_i,
  input  logic [ADDR_W-1:0] c1_in_addr_i,
  input  logic              c1_out_we_i,
  input  logic [ADDR_W-1:0] c1_out_addr_i,
  input  logic [DATA_W-1:0] c1_out_wdata_i,
  output logic              c3_start_o,
  input  logic              c3_finish_i,
  input  logic              c3_in_req_i,
  input  logic [ADDR_W-1:0] c3_in_addr_i,
  input  logic              c3_wt_req_i,
  input  logic [ADDR_W-1:0] c3_wt_addr_i,
  input  logic              c3_out_we_i,
  input  logic [ADDR_W-1:0] c3_out_addr_i,
  input  logic [DATA_W-1:0] c3_out_wdata_i,
  output logic              mp_start_o,
  input  logic              mp_finish_i,
  input  logic              mp_in_req_i,
  input  logic [ADDR_W-1:0] mp_in_addr_i,
  input  logic              mp_out_we_i,
  input  logic [ADDR_W-1:0] mp_out_addr_i,
  input  logic [DATA_W-1:0] mp_out_wdata_i
);

  logic      busy_q;
  logic      accept;
  acc_mode_e mode_q;

  // Start only when idle and the code is a known mode
  assign accept     = start_i && !busy_q && mode_valid(mode_i);
  assign c1_start_o = accept && (mode_i == MODE_CONV_1X1);
  assign c3_start_o = accept && (mode_i == MODE_CONV_3X3);
  assign mp_start_o = accept && (mode_i == MODE_MAX_POOL);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (finish_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mode_q <= mode_i;
    end
  end

  always_comb begin
    finish_o    = 1'b0;
    in_req_o    = 1'b0;
    in_addr_o   = '0;
    wt_req_o    = 1'b0;
    wt_addr_o   = '0;
    out_we_o    = 1'b0;
    out_addr_o  = '0;
    out_wdata_o = '0;
    if (busy_q) begin
      case (mode_q)
        MODE_CONV_1X1: begin
          finish_o    = c1_finish_i;
          in_req_o    = c1_in_req_i;
          in_addr_o   = c1_in_addr_i;
          out_we_o    = c1_out_we_i;
          out_addr_o  = c1_out_addr_i;
          out_wdata_o = c1_out_wdata_i;
        end
        MODE_CONV_3X3: begin
          finish_o    = c3_finish_i;
          in_req_o    = c3_in_req_i;
          in_addr_o   = c3_in_addr_i;
          wt_req_o    = c3_wt_req_i;
          wt_addr_o   = c3_wt_addr_i;
          out_we_o    = c3_out_we_i;
          out_addr_o  = c3_out_addr_i;
          out_wdata_o = c3_out_wdata_i;
        end
        MODE_MAX_POOL: begin
          finish_o    = mp_finish_i;
          in_req_o    = mp_in_req_i;
          in_addr_o   = mp_in_addr_i;
          out_we_o    = mp_out_we_i;
          out_addr_o  = mp_out_addr_i;
          out_wdata_o = mp_out_wdata_i;
        end
        default: ;
      endcase
    end
  end

  // Only the started unit may touch the RAMs
  a_one_unit_on_bus: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({c1_in_req_i | c1_out_we_i,
              c3_in_req_i | c3_wt_req_i | c3_out_we_i,
              mp_in_req_i | mp_out_we_i}));

  a_no_idle_finish: assert property (@(posedge clk) disable iff (!rst_n_i)
    !busy_q |-> !(c1_finish_i || c3_finish_i || mp_finish_i));

endmodule

/* src/max_pool.sv */
`timescale 1ns/1ps

module max_pool import acc_cfg_pkg::*, acc_ops_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  output logic              finish_o,
  output logic              in_req_o,
  output logic [ADDR_W-1:0] in_addr_o,
  input  logic [DATA_W-1:0] in_rdata_i,
  output logic              out_we_o,
  output logic [ADDR_W-1:0] out_addr_o,
  output logic [DATA_W-1:0] out_wdata_o
);

  unit_state_e              state_q;
  logic [1:0]               win_q, win1_q;
  logic [1:0]               row_q, col_q;
  logic                     rd_vld1_q, wr_pend_q;
  logic                     last_win;
  logic [ADDR_W-1:0]        oaddr1_q, out_addr_q;
  logic signed [PIX_W-1:0]  pix, max_q;
  logic signed [DATA_W-1:0] max_ext;

  assign last_win = (win_q == 2'(POOL_WIN * POOL_WIN - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      win_q     <= '0;
      win1_q    <= '0;
      row_q     <= '0;
      col_q     <= '0;
      rd_vld1_q <= 1'b0;
      wr_pend_q <= 1'b0;
      finish_o  <= 1'b0;
    end else begin
      rd_vld1_q <= in_req_o;
      win1_q    <= win_q;
      wr_pend_q <= rd_vld1_q && (win1_q == 2'(POOL_WIN * POOL_WIN - 1));
      finish_o  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_RUN;
            win_q   <= '0;
            row_q   <= '0;
            col_q   <= '0;
          end
        end
        ST_RUN: begin
          win_q <= win_q + 1'b1;
          if (last_win) begin
            col_q <= col_q + 1'b1;
            if (col_q == 2'(POOL_DIM - 1)) begin
              row_q <= row_q + 1'b1;
              if (row_q == 2'(POOL_DIM - 1)) state_q <= ST_DRAIN;
            end
          end
        end
        ST_DRAIN: begin
          // Last window max is written this cycle
          if (wr_pend_q) begin
            finish_o <= 1'b1;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign pix = $signed(in_rdata_i[PIX_W-1:0]);

  always_ff @(posedge clk) begin
    if (rd_vld1_q && (win1_q == '0 || pix > max_q)) begin
      max_q <= pix;
    end
    oaddr1_q <= ADDR_W'(int'(row_q) * POOL_DIM + int'(col_q));
    if (rd_vld1_q && win1_q == 2'(POOL_WIN * POOL_WIN - 1)) begin
      out_addr_q <= oaddr1_q;
    end
  end

  assign in_req_o  = (state_q == ST_RUN);
  assign in_addr_o = ADDR_W'((POOL_WIN * int'(row_q) + int'(win_q) / POOL_WIN) * FMAP_DIM
                             + POOL_WIN * int'(col_q) + int'(win_q) % POOL_WIN);

  assign max_ext     = max_q;
  assign out_we_o    = wr_pend_q;
  assign out_addr_o  = out_addr_q;
  assign out_wdata_o = max_ext;

endmodule

/* conv/conv_1x1.sv */
`timescale 1ns/1ps

module conv_1x1 import acc_cfg_pkg::*, acc_ops_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  output logic              finish_o,
  input  logic [DATA_W-1:0] w8_i,
  output logic              in_req_o,
  output logic [ADDR_W-1:0] in_addr_o,
  input  logic [DATA_W-1:0] in_rdata_i,
  output logic              out_we_o,
  output logic [ADDR_W-1:0] out_addr_o,
  output logic [DATA_W-1:0] out_wdata_o
);

  unit_state_e                state_q;
  logic [ADDR_W-1:0]          cnt_q, addr1_q, addr2_q;
  logic                       valid1_q, valid2_q;
  logic signed [PIX_W-1:0]    weight_q;
  logic signed [15:0]         bias_q;
  logic signed [2*PIX_W-1:0]  prod_q;
  logic signed [DATA_W-1:0]   prod_ext, bias_ext;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q  <= ST_IDLE;
      cnt_q    <= '0;
      valid1_q <= 1'b0;
      valid2_q <= 1'b0;
      finish_o <= 1'b0;
    end else begin
      valid1_q <= in_req_o;
      valid2_q <= valid1_q;
      finish_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_RUN;
            cnt_q   <= '0;
          end
        end
        ST_RUN: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == ADDR_W'(FMAP_PIX - 1)) state_q <= ST_DRAIN;
        end
        ST_DRAIN: begin
          // Pipeline empties with the last write
          if (valid2_q && !valid1_q) begin
            finish_o <= 1'b1;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_i && state_q == ST_IDLE) begin
      weight_q <= w8_i[PIX_W-1:0];
      bias_q   <= w8_i[31:16];
    end
    addr1_q <= cnt_q;
    addr2_q <= addr1_q;
    prod_q  <= $signed(in_rdata_i[PIX_W-1:0]) * weight_q;
  end

  assign in_req_o  = (state_q == ST_RUN);
  assign in_addr_o = cnt_q;

  assign prod_ext    = prod_q;
  assign bias_ext    = bias_q;
  assign out_we_o    = valid2_q;
  assign out_addr_o  = addr2_q;
  assign out_wdata_o = prod_ext + bias_ext;

  // Done only once the last pixel of the map is written
  a_finish_after_last_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    finish_o |-> $past(out_we_o) && $past(out_addr_o) == ADDR_W'(FMAP_PIX - 1));

endmodule

/* conv/conv_3x3.sv */
`timescale 1ns/1ps

module conv_3x3 import acc_cfg_pkg::*, acc_ops_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  output logic              finish_o,
  input  logic [DATA_W-1:0] w8_i,
  output logic              in_req_o,
  output logic [ADDR_W-1:0] in_addr_o,
  input  logic [DATA_W-1:0] in_rdata_i,
  output logic              wt_req_o,
  output logic [ADDR_W-1:0] wt_addr_o,
  input  logic [DATA_W-1:0] wt_rdata_i,
  output logic              out_we_o,
  output logic [ADDR_W-1:0] out_addr_o,
  output logic [DATA_W-1:0] out_wdata_o
);

  unit_state_e              state_q;
  logic [3:0]               tap_q, tap1_q;
  logic [2:0]               row_q, col_q;
  logic                     in_vld1_q, wt_vld1_q, wr_pend_q;
  logic                     last_tap;
  logic [ADDR_W-1:0]        oaddr1_q, out_addr_q;
  logic signed [PIX_W-1:0]  weight_rf [KERNEL_TAPS];
  logic signed [15:0]       bias_q;
  logic signed [DATA_W-1:0] acc_q, prod_ext, bias_ext;

  assign last_tap = (tap_q == 4'(KERNEL_TAPS - 1));

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q   <= ST_IDLE;
      tap_q     <= '0;
      tap1_q    <= '0;
      row_q     <= '0;
      col_q     <= '0;
      in_vld1_q <= 1'b0;
      wt_vld1_q <= 1'b0;
      wr_pend_q <= 1'b0;
      finish_o  <= 1'b0;
    end else begin
      in_vld1_q <= in_req_o;
      wt_vld1_q <= wt_req_o;
      tap1_q    <= tap_q;
      wr_pend_q <= in_vld1_q && (tap1_q == 4'(KERNEL_TAPS - 1));
      finish_o  <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q <= ST_LOAD;
            tap_q   <= '0;
            row_q   <= '0;
            col_q   <= '0;
          end
        end
        ST_LOAD: begin
          tap_q <= last_tap ? '0 : tap_q + 1'b1;
          if (last_tap) state_q <= ST_RUN;
        end
        ST_RUN: begin
          tap_q <= last_tap ? '0 : tap_q + 1'b1;
          if (last_tap) begin
            if (col_q == 3'(CONV3_DIM - 1)) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
              if (row_q == 3'(CONV3_DIM - 1)) state_q <= ST_DRAIN;
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
        ST_DRAIN: begin
          if (wr_pend_q) begin
            finish_o <= 1'b1;
            state_q  <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign prod_ext = $signed(in_rdata_i[PIX_W-1:0]) * weight_rf[tap1_q];
  assign bias_ext = bias_q;

  always_ff @(posedge clk) begin
    if (start_i && state_q == ST_IDLE) begin
      bias_q <= w8_i[31:16];
    end
    if (wt_vld1_q) begin
      weight_rf[tap1_q] <= wt_rdata_i[PIX_W-1:0];
    end
    // First tap restarts the sum for a new output
    if (in_vld1_q) begin
      acc_q <= (tap1_q == '0) ? prod_ext : acc_q + prod_ext;
    end
    oaddr1_q <= ADDR_W'(int'(row_q) * CONV3_DIM + int'(col_q));
    if (in_vld1_q && tap1_q == 4'(KERNEL_TAPS - 1)) begin
      out_addr_q <= oaddr1_q;
    end
  end

  assign wt_req_o  = (state_q == ST_LOAD);
  assign wt_addr_o = ADDR_W'(tap_q);
  assign in_req_o  = (state_q == ST_RUN);
  assign in_addr_o = ADDR_W'((int'(row_q) + int'(tap_q) / KERNEL_DIM) * FMAP_DIM
                             + int'(col_q) + int'(tap_q) % KERNEL_DIM);

  assign out_we_o    = wr_pend_q;
  assign out_addr_o  = out_addr_q;
  assign out_wdata_o = acc_q + bias_ext;

  a_tap_in_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    (in_req_o || wt_req_o) |-> tap_q < KERNEL_TAPS);

endmodule

/* src/conv_acc.sv */
`timescale 1ns/1ps

module conv_acc import acc_cfg_pkg::*, acc_ops_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  acc_mode_e         mode_i,
  input  logic [DATA_W-1:0] w8_i,
  output logic              finish_o,
  output logic              in_req_o,
  output logic [ADDR_W-1:0] in_addr_o,
  input  logic [DATA_W-1:0] in_rdata_i,
  output logic              wt_req_o,
  output logic [ADDR_W-1:0] wt_addr_o,
  input  logic [DATA_W-1:0] wt_rdata_i,
  output logic              out_we_o,
  output logic [ADDR_W-1:0] out_addr_o,
  output logic [DATA_W-1:0] out_wdata_o
);

  // Pointwise unit
  logic              c1_start, c1_finish, c1_in_req, c1_out_we;
  logic [ADDR_W-1:0] c1_in_addr, c1_out_addr;
  logic [DATA_W-1:0] c1_out_wdata;

  // 3x3 unit
  logic              c3_start, c3_finish, c3_in_req, c3_wt_req, c3_out_we;
  logic [ADDR_W-1:0] c3_in_addr, c3_wt_addr, c3_out_addr;
  logic [DATA_W-1:0] c3_out_wdata;

  // Pooling unit
  logic              mp_start, mp_finish, mp_in_req, mp_out_we;
  logic [ADDR_W-1:0] mp_in_addr, mp_out_addr;
  logic [DATA_W-1:0] mp_out_wdata;

  bus_switcher i_bus_switcher (
    .clk, .rst_n_i, .start_i, .mode_i, .finish_o,
    .in_req_o, .in_addr_o, .wt_req_o, .wt_addr_o,
    .out_we_o, .out_addr_o, .out_wdata_o,
    .c1_start_o(c1_start), .c1_finish_i(c1_finish),
    .c1_in_req_i(c1_in_req), .c1_in_addr_i(c1_in_addr),
    .c1_out_we_i(c1_out_we), .c1_out_addr_i(c1_out_addr), .c1_out_wdata_i(c1_out_wdata),
    .c3_start_o(c3_start), .c3_finish_i(c3_finish),
    .c3_in_req_i(c3_in_req), .c3_in_addr_i(c3_in_addr),
    .c3_wt_req_i(c3_wt_req), .c3_wt_addr_i(c3_wt_addr),
    .c3_out_we_i(c3_out_we), .c3_out_addr_i(c3_out_addr), .c3_out_wdata_i(c3_out_wdata),
    .mp_start_o(mp_start), .mp_finish_i(mp_finish),
    .mp_in_req_i(mp_in_req), .mp_in_addr_i(mp_in_addr),
    .mp_out_we_i(mp_out_we), .mp_out_addr_i(mp_out_addr), .mp_out_wdata_i(mp_out_wdata)
  );

  conv_1x1 i_conv_1x1 (
    .clk, .rst_n_i, .w8_i,
    .start_i(c1_start), .finish_o(c1_finish),
    .in_req_o(c1_in_req), .in_addr_o(c1_in_addr), .in_rdata_i,
    .out_we_o(c1_out_we), .out_addr_o(c1_out_addr), .out_wdata_o(c1_out_wdata)
  );

  conv_3x3 i_conv_3x3 (
    .clk, .rst_n_i, .w8_i,
    .start_i(c3_start), .finish_o(c3_finish),
    .in_req_o(c3_in_req), .in_addr_o(c3_in_addr), .in_rdata_i,
    .wt_req_o(c3_wt_req), .wt_addr_o(c3_wt_addr), .wt_rdata_i,
    .out_we_o(c3_out_we), .out_addr_o(c3_out_addr), .out_wdata_o(c3_out_wdata)
  );

  max_pool i_max_pool (
    .clk, .rst_n_i,
    .start_i(mp_start), .finish_o(mp_finish),
    .in_req_o(mp_in_req), .in_addr_o(mp_in_addr), .in_rdata_i,
    .out_we_o(mp_out_we), .out_addr_o(mp_out_addr), .out_wdata_o(mp_out_wdata)
  );

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset low over two rising edges, released on a falling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* dv/tb_conv_acc.sv */
`timescale 1ns/1ps

module tb_conv_acc import acc_cfg_pkg::*, acc_ops_pkg::*;;

  // About 400 cycles per operation, seven operations and one idle wait
  localparam int MAX_OP_CYCLES  = 400;
  localparam int NUM_OPS        = 7;
  localparam int IDLE_WAIT      = 200;
  localparam int TIMEOUT_CYCLES = NUM_OPS * MAX_OP_CYCLES + IDLE_WAIT + 1000;

  logic              clk, rst_n;
  logic              start;
  acc_mode_e         mode;
  logic [DATA_W-1:0] w8;
  logic              finish;
  logic              in_req, wt_req, out_we;
  logic [ADDR_W-1:0] in_addr, wt_addr, out_addr;
  logic [DATA_W-1:0] in_rdata = '0;
  logic [DATA_W-1:0] wt_rdata = '0;
  logic [DATA_W-1:0] out_wdata;

  logic [DATA_W-1:0] in_ram  [FMAP_PIX];
  logic [DATA_W-1:0] wt_ram  [FMAP_PIX];
  logic [DATA_W-1:0] out_ram [FMAP_PIX];
  logic [DATA_W-1:0] exp_mem [FMAP_PIX];
  logic              clear_req;
  logic [31:0]       lfsr_state = 32'h5dc2_0cec;
  int                wr_cnt, exp_cnt, start_cnt;
  int                finish_cnt = 0;
  int                cycle_cnt = 0;
  string             test_name;

  tb_clk_gen u_clk_gen (
    .clk_o(clk),
    .rst_n_o(rst_n)
  );

  conv_acc u_dut (
    .clk(clk), .rst_n_i(rst_n), .start_i(start), .mode_i(mode), .w8_i(w8),
    .finish_o(finish),
    .in_req_o(in_req), .in_addr_o(in_addr), .in_rdata_i(in_rdata),
    .wt_req_o(wt_req), .wt_addr_o(wt_addr), .wt_rdata_i(wt_rdata),
    .out_we_o(out_we), .out_addr_o(out_addr), .out_wdata_o(out_wdata)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hd000_0001 : lfsr_state >> 1;
    end
    return val;
  endfunction

  // Unwritten output words keep this marker
  function automatic logic [DATA_W-1:0] fill_word(int a);
    return {16'hdead, 10'h000, ADDR_W'(a)};
  endfunction

  function automatic int pix_at(int a);
    return int'($signed(in_ram[a][PIX_W-1:0]));
  endfunction

  function automatic int wt_at(int a);
    return int'($signed(wt_ram[a][PIX_W-1:0]));
  endfunction

  // Fills exp_mem for one operation and returns the number of outputs
  function automatic int ref_model(acc_mode_e op, logic [DATA_W-1:0] w8_word);
    int bias, sum, best, pix, n;
    bias = int'($signed(w8_word[31:16]));
    n = 0;
    case (op)
      MODE_CONV_1X1: begin
        for (int p = 0; p < FMAP_PIX; p++) begin
          exp_mem[p] = pix_at(p) * int'($signed(w8_word[PIX_W-1:0])) + bias;
        end
        n = FMAP_PIX;
      end
      MODE_CONV_3X3: begin
        for (int r = 0; r < CONV3_DIM; r++) begin
          for (int c = 0; c < CONV3_DIM; c++) begin
            sum = bias;
            for (int t = 0; t < KERNEL_TAPS; t++) begin
              sum += pix_at((r + t / KERNEL_DIM) * FMAP_DIM + c + t % KERNEL_DIM) * wt_at(t);
            end
            exp_mem[r * CONV3_DIM + c] = sum;
          end
        end
        n = CONV3_DIM * CONV3_DIM;
      end
      MODE_MAX_POOL: begin
        for (int r = 0; r < POOL_DIM; r++) begin
          for (int c = 0; c < POOL_DIM; c++) begin
            best = pix_at(2 * r * FMAP_DIM + 2 * c);
            for (int t = 1; t < 4; t++) begin
              pix = pix_at((2 * r + t / 2) * FMAP_DIM + 2 * c + t % 2);
              if (pix > best) best = pix;
            end
            exp_mem[r * POOL_DIM + c] = best;
          end
        end
        n = POOL_DIM * POOL_DIM;
      end
      default: n = 0;
    endcase
    return n;
  endfunction

  task automatic check_value(string name, string what, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s: %s expected %0d, actual %0d", name, what, $signed(exp),
               $signed(act));
      $display("Test FAILED");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic stop_run(string msg);
    $display("Error in test %s: %s", test_name, msg);
    $display("Test FAILED");
    $fatal(1, "Run stopped");
  endtask

  // RAM models: registered read, write on out_we
  always @(posedge clk) begin
    if (in_req) in_rdata <= in_ram[in_addr];
    if (wt_req) wt_rdata <= wt_ram[wt_addr];
    if (clear_req) begin
      for (int a = 0; a < FMAP_PIX; a++) out_ram[a] = fill_word(a);
      wr_cnt = 0;
    end else if (out_we) begin
      out_ram[out_addr] = out_wdata;
      wr_cnt++;
    end
  end

  // Result compare after each finish
  always @(negedge clk) begin
    if (rst_n && finish) begin
      if (start_cnt <= finish_cnt) stop_run("finish_o without a valid start");
      check_value(test_name, "write count", exp_cnt, wr_cnt);
      for (int a = 0; a < FMAP_PIX; a++) begin
        if (a < exp_cnt) begin
          check_value(test_name, $sformatf("word %0d", a), exp_mem[a], out_ram[a]);
        end else begin
          check_value(test_name, $sformatf("unused word %0d", a), fill_word(a), out_ram[a]);
        end
      end
      finish_cnt++;
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles in test %s", cycle_cnt, test_name);
      $display("Test FAILED");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic clear_out_ram();
    @(negedge clk);
    clear_req = 1'b1;
    @(negedge clk);
    clear_req = 1'b0;
  endtask

  task automatic load_random_data();
    for (int a = 0; a < FMAP_PIX; a++) begin
      in_ram[a] = rand_bits(DATA_W);
      wt_ram[a] = rand_bits(DATA_W);
    end
  endtask

  // Diagonal pooling windows hold only negative pixels
  task automatic make_negative_windows();
    int a;
    for (int w = 0; w < POOL_DIM; w++) begin
      for (int t = 0; t < 4; t++) begin
        a = (2 * w + t / 2) * FMAP_DIM + 2 * w + t % 2;
        in_ram[a][PIX_W-1] = 1'b1;
      end
    end
  endtask

  task automatic run_op(string name, acc_mode_e op, logic [DATA_W-1:0] w8_word);
    int done;
    done = finish_cnt;
    test_name = name;
    exp_cnt = ref_model(op, w8_word);
    clear_out_ram();
    start = 1'b1;
    mode = op;
    w8 = w8_word;
    start_cnt++;
    @(negedge clk);
    start = 1'b0;
    // Units latch w8 at start
    w8 = rand_bits(DATA_W);
    while (finish_cnt == done) @(negedge clk);
  endtask

  initial begin
    start = 1'b0;
    mode = MODE_CONV_1X1;
    w8 = '0;
    clear_req = 1'b0;
    start_cnt = 0;
    exp_cnt = 0;
    test_name = "reset";
    @(posedge rst_n);
    @(negedge clk);

    load_random_data();
    run_op("pointwise", MODE_CONV_1X1, rand_bits(DATA_W));
    run_op("conv 3x3", MODE_CONV_3X3, rand_bits(DATA_W));
    make_negative_windows();
    run_op("max pool", MODE_MAX_POOL, rand_bits(DATA_W));

    load_random_data();
    run_op("back to back 3x3", MODE_CONV_3X3, rand_bits(DATA_W));
    run_op("back to back pool", MODE_MAX_POOL, rand_bits(DATA_W));
    run_op("back to back 1x1", MODE_CONV_1X1, rand_bits(DATA_W));

    test_name = "invalid mode";
    exp_cnt = 0;
    clear_out_ram();
    start = 1'b1;
    mode = acc_mode_e'(4'hf);
    @(negedge clk);
    start = 1'b0;
    repeat (IDLE_WAIT) @(negedge clk);
    check_value(test_name, "write count", 0, wr_cnt);
    run_op("after invalid mode", MODE_CONV_3X3, rand_bits(DATA_W));

    $display("Test OK");
    $finish;
  end

endmodule

/* verilog.f */
common/acc_cfg_pkg.sv
common/acc_ops_pkg.sv
src/bus_switcher.sv
src/max_pool.sv
conv/conv_1x1.sv
conv/conv_3x3.sv
src/conv_acc.sv
dv/tb_clk_gen.sv
dv/tb_conv_acc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the accelerator testbench with Verilator

set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module tb_conv_acc --Mdir obj_dir -o tb_conv_acc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_conv_acc 2>&1 | tee "$LOG"
run_status=$?

if grep -q "Test FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

exit 0
